// ==== hw/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

    // ========================================
    // Beat geometry
    // ========================================

    // Bytes carried by one bus beat
    localparam int BEAT_BYTES = 8;

    // Beat payload, byte 0 in the low bits
    typedef logic [BEAT_BYTES*8-1:0] beat_data_t;

    // Per-byte valid mask, contiguous from byte 0
    typedef logic [BEAT_BYTES-1:0] beat_keep_t;

    // Packet and truncation lengths in bytes
    typedef logic [15:0] pkt_len_t;

endpackage

`default_nettype wire

// ==== hw/trunc_cfg_pkg.sv ====
`default_nettype none

package trunc_cfg_pkg;

    // ========================================
    // Lane and buffer sizing
    // ========================================

    // Parallel truncation lanes
    localparam int NUM_LANES = 4;
    typedef logic [1:0] lane_idx_t;

    // Dispatcher input buffer, in beats
    localparam int IN_DEPTH = 8;

    // Per-lane output buffer, in beats
    localparam int LANE_DEPTH = 4;

    // ========================================
    // Credit accounting
    // ========================================

    // Ceiling on sink credits held by the merger
    localparam int OUT_CREDIT_MAX = 15;
    typedef logic [3:0] credit_cnt_t;

    // Credits handed back by a lane in one cycle, 0 to 2
    typedef logic [1:0] credit_ret_t;

    // Lane FSM: first beat, inside packet, discarding tail
    typedef enum logic [1:0] {FIRST, BODY, DROP} lane_state_e;

    // Merger FSM: waiting on lane, draining packet
    typedef enum logic {IDLE, SEND} merge_state_e;

endpackage

`default_nettype wire

// ==== hw/beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     wr_en,
    input  wire stream_pkg::beat_data_t wr_data,
    input  wire stream_pkg::beat_keep_t wr_keep,
    input  wire                     wr_last,
    input  wire                     rd_en,
    output logic                    rd_valid,
    output stream_pkg::beat_data_t  rd_data,
    output stream_pkg::beat_keep_t  rd_keep,
    output logic                    rd_last,
    output logic                    full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, one beat per entry
    stream_pkg::beat_data_t mem_data [DEPTH];
    stream_pkg::beat_keep_t mem_keep [DEPTH];
    logic                   mem_last [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Writes into a full buffer are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && rd_valid;

    // Head entry always on the read side
    assign rd_valid = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign rd_data  = mem_data[rd_ptr];
    assign rd_keep  = mem_keep[rd_ptr];
    assign rd_last  = mem_last[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr_data;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    // Pointers wrap at DEPTH, any depth allowed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

endmodule

`default_nettype wire

// ==== hw/pkt_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_dispatch (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    input  wire stream_pkg::beat_data_t  in_data,
    input  wire stream_pkg::beat_keep_t  in_keep,
    input  wire                          in_last,
    input  wire stream_pkg::pkt_len_t    trunc_len,
    input  wire trunc_cfg_pkg::credit_ret_t lane_credit_ret [trunc_cfg_pkg::NUM_LANES],
    output logic                         in_credit,
    output logic [trunc_cfg_pkg::NUM_LANES-1:0] lane_valid,
    output stream_pkg::beat_data_t       lane_data,
    output stream_pkg::beat_keep_t       lane_keep,
    output logic                         lane_last,
    output stream_pkg::pkt_len_t         lane_len
);

    // ========================================
    // Input beat and length buffers
    // ========================================

    logic                   buf_valid;
    stream_pkg::beat_data_t buf_data;
    stream_pkg::beat_keep_t buf_keep;
    logic                   buf_last;
    logic                   buf_full;
    logic                   pop;

    beat_fifo #(
        .DEPTH (trunc_cfg_pkg::IN_DEPTH)
    ) u_in_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (in_valid),
        .wr_data  (in_data),
        .wr_keep  (in_keep),
        .wr_last  (in_last),
        .rd_en    (pop),
        .rd_valid (buf_valid),
        .rd_data  (buf_data),
        .rd_keep  (buf_keep),
        .rd_last  (buf_last),
        .full     (buf_full)
    );

    // One length per packet, head matches packet at beat buffer head
    stream_pkg::pkt_len_t len_mem [trunc_cfg_pkg::IN_DEPTH];
    logic [$clog2(trunc_cfg_pkg::IN_DEPTH)-1:0] len_wr_ptr;
    logic [$clog2(trunc_cfg_pkg::IN_DEPTH)-1:0] len_rd_ptr;
    logic in_first;

    // Length sampled on first beat only
    always_ff @(posedge clk) begin
        if (in_valid && in_first && !buf_full) begin
            len_mem[len_wr_ptr] <= trunc_len;
        end
    end

    // ========================================
    // Credits and lane steering
    // ========================================

    trunc_cfg_pkg::credit_cnt_t credit_pend;
    trunc_cfg_pkg::credit_cnt_t lane_cnt [trunc_cfg_pkg::NUM_LANES];
    trunc_cfg_pkg::lane_idx_t   cur_lane;

    // Current lane must hold a credit
    assign pop = buf_valid && (lane_cnt[cur_lane] != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_first    <= 1'b1;
            len_wr_ptr  <= '0;
            len_rd_ptr  <= '0;
            // Initial burst equals the buffer depth
            credit_pend <= trunc_cfg_pkg::credit_cnt_t'(trunc_cfg_pkg::IN_DEPTH);
            in_credit   <= 1'b0;
            cur_lane    <= '0;
            lane_valid  <= '0;
            lane_data   <= '0;
            lane_keep   <= '0;
            lane_last   <= 1'b0;
            lane_len    <= '0;
            for (int i = 0; i < trunc_cfg_pkg::NUM_LANES; i++) begin
                lane_cnt[i] <= trunc_cfg_pkg::credit_cnt_t'(trunc_cfg_pkg::LANE_DEPTH);
            end
        end else begin
            if (in_valid && !buf_full) begin
                in_first <= in_last;
                if (in_first) begin
                    len_wr_ptr <= len_wr_ptr + 1'b1;
                end
            end
            // One pulse per cycle while any credit is owed, each pop owes one more
            in_credit   <= (credit_pend != '0);
            credit_pend <= credit_pend + trunc_cfg_pkg::credit_cnt_t'(pop)
                           - trunc_cfg_pkg::credit_cnt_t'(credit_pend != '0);
            // Per-lane credits: spent on send, refilled by lane returns
            for (int i = 0; i < trunc_cfg_pkg::NUM_LANES; i++) begin
                lane_cnt[i] <= lane_cnt[i]
                    + trunc_cfg_pkg::credit_cnt_t'(lane_credit_ret[i])
                    - trunc_cfg_pkg::credit_cnt_t'(pop && (cur_lane == i));
            end
            // Registered lane port, zero when idle
            lane_valid <= '0;
            lane_data  <= '0;
            lane_keep  <= '0;
            lane_last  <= 1'b0;
            if (pop) begin
                lane_valid[cur_lane] <= 1'b1;
                lane_data            <= buf_data;
                lane_keep            <= buf_keep;
                lane_last            <= buf_last;
                lane_len             <= len_mem[len_rd_ptr];
                // Whole packet done, rotate
                if (buf_last) begin
                    cur_lane   <= cur_lane + 1'b1;
                    len_rd_ptr <= len_rd_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/trunc_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module trunc_lane (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         beat_valid,
    input  wire stream_pkg::beat_data_t beat_data,
    input  wire stream_pkg::beat_keep_t beat_keep,
    input  wire                         beat_last,
    input  wire stream_pkg::pkt_len_t   beat_len,
    input  wire                         pop,
    output trunc_cfg_pkg::credit_ret_t  credit_ret,
    output logic                        q_valid,
    output stream_pkg::beat_data_t      q_data,
    output stream_pkg::beat_keep_t      q_keep,
    output logic                        q_last
);

    trunc_cfg_pkg::lane_state_e state;
    stream_pkg::pkt_len_t       len_q;
    stream_pkg::pkt_len_t       byte_cnt;

    stream_pkg::pkt_len_t   remain;
    logic                   cut;
    logic                   drop;
    logic                   keep_beat;
    stream_pkg::beat_keep_t keep_out;
    stream_pkg::beat_data_t data_out;
    logic                   last_out;
    logic                   fifo_full;

    // ========================================
    // Cut computation
    // ========================================

    always_comb begin
        // Length and count come straight from the port on a first beat
        if (state == trunc_cfg_pkg::FIRST) begin
            remain = beat_len;
        end else begin
            remain = len_q - byte_cnt;
        end
        cut       = (remain <= stream_pkg::pkt_len_t'(stream_pkg::BEAT_BYTES));
        drop      = beat_valid && (state == trunc_cfg_pkg::DROP);
        keep_beat = beat_valid && (state != trunc_cfg_pkg::DROP);
        last_out  = beat_last || cut;
        // Lanes at or past the cut lose keep
        for (int i = 0; i < stream_pkg::BEAT_BYTES; i++) begin
            keep_out[i] = beat_keep[i] && (stream_pkg::pkt_len_t'(i) < remain);
        end
        // Unkept bytes always zero
        for (int i = 0; i < stream_pkg::BEAT_BYTES; i++) begin
            data_out[i*8 +: 8] = keep_out[i] ? beat_data[i*8 +: 8] : 8'h00;
        end
    end

    // ========================================
    // Packet FSM
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= trunc_cfg_pkg::FIRST;
            len_q    <= '0;
            byte_cnt <= '0;
        end else if (beat_valid) begin
            if (state == trunc_cfg_pkg::FIRST) begin
                len_q <= beat_len;
            end
            // Full beats before the cut, so count in whole beats
            if (state == trunc_cfg_pkg::FIRST) begin
                byte_cnt <= stream_pkg::pkt_len_t'(stream_pkg::BEAT_BYTES);
            end else begin
                byte_cnt <= byte_cnt + stream_pkg::pkt_len_t'(stream_pkg::BEAT_BYTES);
            end
            if (beat_last) begin
                state <= trunc_cfg_pkg::FIRST;
            end else if (state == trunc_cfg_pkg::DROP || cut) begin
                state <= trunc_cfg_pkg::DROP;
            end else begin
                state <= trunc_cfg_pkg::BODY;
            end
        end
    end

    // Output buffer, written at the edge ending the arrival cycle
    beat_fifo #(
        .DEPTH (trunc_cfg_pkg::LANE_DEPTH)
    ) u_lane_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (keep_beat && !fifo_full),
        .wr_data  (data_out),
        .wr_keep  (keep_out),
        .wr_last  (last_out),
        .rd_en    (pop),
        .rd_valid (q_valid),
        .rd_data  (q_data),
        .rd_keep  (q_keep),
        .rd_last  (q_last),
        .full     (fifo_full)
    );

    // Popped and dropped beats both free a dispatcher credit
    assign credit_ret = trunc_cfg_pkg::credit_ret_t'(pop && q_valid)
                        + trunc_cfg_pkg::credit_ret_t'(drop);

endmodule

`default_nettype wire

// ==== hw/pkt_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_merge (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [trunc_cfg_pkg::NUM_LANES-1:0] q_valid,
    input  wire stream_pkg::beat_data_t q_data [trunc_cfg_pkg::NUM_LANES],
    input  wire stream_pkg::beat_keep_t q_keep [trunc_cfg_pkg::NUM_LANES],
    input  wire                         q_last [trunc_cfg_pkg::NUM_LANES],
    input  wire                         out_credit,
    output logic [trunc_cfg_pkg::NUM_LANES-1:0] q_pop,
    output logic                        out_valid,
    output stream_pkg::beat_data_t      out_data,
    output stream_pkg::beat_keep_t      out_keep,
    output logic                        out_last
);

    trunc_cfg_pkg::merge_state_e state;
    trunc_cfg_pkg::lane_idx_t    cur_lane;
    trunc_cfg_pkg::credit_cnt_t  credit_cnt;
    logic                        do_pop;

    // ========================================
    // Pop decision
    // ========================================

    // Same lane order as the dispatcher, so packet order holds
    assign do_pop = (state == trunc_cfg_pkg::SEND) && q_valid[cur_lane]
                    && (credit_cnt != '0);

    always_comb begin
        q_pop           = '0;
        q_pop[cur_lane] = do_pop;
    end

    // ========================================
    // FSM, credits and output register
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= trunc_cfg_pkg::IDLE;
            cur_lane   <= '0;
            credit_cnt <= '0;
            out_valid  <= 1'b0;
            out_data   <= '0;
            out_keep   <= '0;
            out_last   <= 1'b0;
        end else begin
            // Sink grants add, sent beats spend
            credit_cnt <= credit_cnt + trunc_cfg_pkg::credit_cnt_t'(out_credit)
                          - trunc_cfg_pkg::credit_cnt_t'(do_pop);
            case (state)
                trunc_cfg_pkg::IDLE: begin
                    if (q_valid[cur_lane]) begin
                        state <= trunc_cfg_pkg::SEND;
                    end
                end
                default: begin
                    // End of packet hands over to the next lane
                    if (do_pop && q_last[cur_lane]) begin
                        state    <= trunc_cfg_pkg::IDLE;
                        cur_lane <= cur_lane + 1'b1;
                    end
                end
            endcase
            // Everything zero when no beat goes out
            out_valid <= do_pop;
            out_data  <= do_pop ? q_data[cur_lane] : '0;
            out_keep  <= do_pop ? q_keep[cur_lane] : '0;
            out_last  <= do_pop && q_last[cur_lane];
        end
    end

endmodule

`default_nettype wire

// ==== hw/pkt_trunc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_trunc_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire stream_pkg::beat_data_t in_data,
    input  wire stream_pkg::beat_keep_t in_keep,
    input  wire                         in_last,
    input  wire stream_pkg::pkt_len_t   trunc_len,
    output logic                        in_credit,
    input  wire                         out_credit,
    output logic                        out_valid,
    output stream_pkg::beat_data_t      out_data,
    output stream_pkg::beat_keep_t      out_keep,
    output logic                        out_last
);

    // Shared dispatcher bus, one-hot valid
    logic [trunc_cfg_pkg::NUM_LANES-1:0] lane_valid;
    stream_pkg::beat_data_t              lane_data;
    stream_pkg::beat_keep_t              lane_keep;
    logic                                lane_last;
    stream_pkg::pkt_len_t                lane_len;
    trunc_cfg_pkg::credit_ret_t          lane_credit_ret [trunc_cfg_pkg::NUM_LANES];

    // Lane buffer heads toward the merger
    logic [trunc_cfg_pkg::NUM_LANES-1:0] q_valid;
    logic [trunc_cfg_pkg::NUM_LANES-1:0] q_pop;
    stream_pkg::beat_data_t              q_data [trunc_cfg_pkg::NUM_LANES];
    stream_pkg::beat_keep_t              q_keep [trunc_cfg_pkg::NUM_LANES];
    logic                                q_last [trunc_cfg_pkg::NUM_LANES];

    pkt_dispatch u_pkt_dispatch (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_keep         (in_keep),
        .in_last         (in_last),
        .trunc_len       (trunc_len),
        .lane_credit_ret (lane_credit_ret),
        .in_credit       (in_credit),
        .lane_valid      (lane_valid),
        .lane_data       (lane_data),
        .lane_keep       (lane_keep),
        .lane_last       (lane_last),
        .lane_len        (lane_len)
    );

    // Identical lanes, packets dealt round-robin
    for (genvar i = 0; i < trunc_cfg_pkg::NUM_LANES; i++) begin : g_lane
        trunc_lane u_trunc_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .beat_valid (lane_valid[i]),
            .beat_data  (lane_data),
            .beat_keep  (lane_keep),
            .beat_last  (lane_last),
            .beat_len   (lane_len),
            .pop        (q_pop[i]),
            .credit_ret (lane_credit_ret[i]),
            .q_valid    (q_valid[i]),
            .q_data     (q_data[i]),
            .q_keep     (q_keep[i]),
            .q_last     (q_last[i])
        );
    end

    pkt_merge u_pkt_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .q_valid    (q_valid),
        .q_data     (q_data),
        .q_keep     (q_keep),
        .q_last     (q_last),
        .out_credit (out_credit),
        .q_pop      (q_pop),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last)
    );

endmodule

`default_nettype wire

// ==== test/tb_pkt_trunc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_trunc;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    stream_pkg::beat_data_t in_data;
    stream_pkg::beat_keep_t in_keep;
    logic                   in_last;
    stream_pkg::pkt_len_t   trunc_len;
    logic                   in_credit;
    logic                   out_credit;
    logic                   out_valid;
    stream_pkg::beat_data_t out_data;
    stream_pkg::beat_keep_t out_keep;
    logic                   out_last;

    // Input beats in send order
    stream_pkg::beat_data_t src_data [$];
    stream_pkg::beat_keep_t src_keep [$];
    logic                   src_last [$];
    stream_pkg::pkt_len_t   src_len [$];

    // Expected output beats in file order
    stream_pkg::beat_data_t exp_data [$];
    stream_pkg::beat_keep_t exp_keep [$];
    logic                   exp_last [$];

    logic [15:0] lfsr;
    logic        crd_bit;
    int          in_held;
    int          out_granted;
    int          out_seen;
    int          wd_limit;

    pkt_trunc_top u_pkt_trunc_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_keep    (in_keep),
        .in_last    (in_last),
        .trunc_len  (trunc_len),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // ========================================
    // Random source and payload model
    // ========================================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // Eight steps per byte, low byte of the register
    task automatic next_byte(output logic [7:0] b);
        repeat (8) lfsr = lfsr_next(lfsr);
        b = lfsr[7:0];
    endtask

    task automatic build_packet(input int len, input int tlen, input int offset);
        logic [7:0]             bytes [$];
        logic [7:0]             b;
        stream_pkg::beat_data_t d;
        stream_pkg::beat_keep_t k;
        int                     out_len;
        int                     idx;
        repeat (offset) lfsr = lfsr_next(lfsr);
        for (int i = 0; i < len; i++) begin
            next_byte(b);
            bytes.push_back(b);
        end
        // Input beats, keep contiguous from byte 0
        for (int bt = 0; bt < (len + 7) / 8; bt++) begin
            d = '0;
            k = '0;
            for (int i = 0; i < stream_pkg::BEAT_BYTES; i++) begin
                idx = bt * stream_pkg::BEAT_BYTES + i;
                if (idx < len) begin
                    d[i*8 +: 8] = bytes[idx];
                    k[i]        = 1'b1;
                end
            end
            src_data.push_back(d);
            src_keep.push_back(k);
            src_last.push_back(bt == (len + 7) / 8 - 1);
            // Only the first beat carries the real length
            if (bt == 0) begin
                src_len.push_back(stream_pkg::pkt_len_t'(tlen));
            end else begin
                src_len.push_back(~stream_pkg::pkt_len_t'(tlen));
            end
        end
        // Output holds the shorter of packet and cut length
        out_len = (len < tlen) ? len : tlen;
        for (int bt = 0; bt < (out_len + 7) / 8; bt++) begin
            d = '0;
            k = '0;
            for (int i = 0; i < stream_pkg::BEAT_BYTES; i++) begin
                idx = bt * stream_pkg::BEAT_BYTES + i;
                if (idx < out_len) begin
                    d[i*8 +: 8] = bytes[idx];
                    k[i]        = 1'b1;
                end
            end
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back(bt == (out_len + 7) / 8 - 1);
        end
    endtask

    // Lines starting with # are column notes
    task automatic read_descriptors();
        int    fd;
        int    n;
        int    len;
        int    tlen;
        int    offset;
        string line;
        fd = $fopen("test/trunc_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the packet descriptor file test/trunc_testdata.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d", len, tlen, offset) == 3) begin
                    build_packet(len, tlen, offset);
                end
            end
        end
        $fclose(fd);
        if (exp_data.size() == 0) begin
            $display("The descriptor file holds no packets");
            stop_on_error();
        end
    endtask

    // ========================================
    // Compare tasks
    // ========================================

    task automatic stop_on_error();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input stream_pkg::beat_data_t exp,
                              input stream_pkg::beat_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_keep(input string name, input stream_pkg::beat_keep_t exp,
                              input stream_pkg::beat_keep_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input trunc_cfg_pkg::credit_cnt_t exp,
                               input trunc_cfg_pkg::credit_cnt_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_on_error();
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        trunc_len   = '0;
        out_credit  = 1'b0;
        lfsr        = 16'd91;
        in_held     = 0;
        out_granted = 0;
        out_seen    = 0;
        wd_limit    = 0;
        read_descriptors();
        wd_limit = src_data.size() * 16 + 1000;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Initial burst arrives on back-to-back cycles
        @(negedge clk);
        while (!in_credit) @(negedge clk);
        while (in_credit) begin
            in_held++;
            if (in_held > trunc_cfg_pkg::IN_DEPTH) begin
                $display("Initial credit burst ran past %0d pulses", trunc_cfg_pkg::IN_DEPTH);
                stop_on_error();
            end
            @(negedge clk);
        end
        check_count("in_credit_burst", trunc_cfg_pkg::credit_cnt_t'(trunc_cfg_pkg::IN_DEPTH),
                    trunc_cfg_pkg::credit_cnt_t'(in_held));

        while (exp_data.size() > 0) begin
            @(negedge clk);
            // Output side, registered so stable here
            if (out_valid) begin
                out_seen++;
                if (out_seen > out_granted) begin
                    $display("Output beat %0d sent with only %0d credits granted",
                             out_seen, out_granted);
                    stop_on_error();
                end
                check_data("out_data", exp_data.pop_front(), out_data);
                check_keep("out_keep", exp_keep.pop_front(), out_keep);
                check_last("out_last", exp_last.pop_front(), out_last);
            end else begin
                check_data("out_data", '0, out_data);
                check_keep("out_keep", '0, out_keep);
                check_last("out_last", 1'b0, out_last);
            end
            // Count credit pulses from the DUT
            if (in_credit) begin
                in_held++;
                if (in_held > trunc_cfg_pkg::IN_DEPTH) begin
                    $display("Input credits held rose to %0d, above the buffer depth", in_held);
                    stop_on_error();
                end
            end
            // One beat per held credit
            if (in_held > 0 && src_data.size() > 0) begin
                in_valid  = 1'b1;
                in_data   = src_data.pop_front();
                in_keep   = src_keep.pop_front();
                in_last   = src_last.pop_front();
                trunc_len = src_len.pop_front();
                in_held--;
            end else begin
                in_valid  = 1'b0;
                in_data   = '0;
                in_keep   = '0;
                in_last   = 1'b0;
                trunc_len = '0;
            end
            // Random sink grants, capped at the merger limit
            take_bit(crd_bit);
            if (crd_bit && (out_granted - out_seen) < trunc_cfg_pkg::OUT_CREDIT_MAX) begin
                out_credit = 1'b1;
                out_granted++;
            end else begin
                out_credit = 1'b0;
            end
        end
        in_valid   = 1'b0;
        out_credit = 1'b0;

        // Every input pop returned its credit
        check_count("in_credit_held", trunc_cfg_pkg::credit_cnt_t'(trunc_cfg_pkg::IN_DEPTH),
                    trunc_cfg_pkg::credit_cnt_t'(in_held));
        $display("STATUS: PASS");
        $finish;
    end

    // Limit scales with the stimulus length
    initial begin
        wait (wd_limit != 0);
        repeat (wd_limit) @(posedge clk);
        $display("Run timed out after %0d cycles with output beats still missing", wd_limit);
        stop_on_error();
    end

endmodule

`default_nettype wire

// ==== test/trunc_testdata.txt ====
# pkt_len trunc_len seed_offset, all decimal
# lengths in bytes, offset is LFSR steps skipped before the payload
64 64 0
100 40 3
13 200 1
30 17 7
8 8 2
1 1 5
120 9 4
45 45 0
50 3 6
7 100 2
24 16 1
90 61 3
16 1 0
33 32 5
72 80 2
57 57 4

// ==== src.f ====
hw/stream_pkg.sv
hw/trunc_cfg_pkg.sv
hw/beat_fifo.sv
hw/pkt_dispatch.sv
hw/trunc_lane.sv
hw/pkt_merge.sv
hw/pkt_trunc_top.sv
test/tb_pkt_trunc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the packet truncation testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_pkt_trunc -f src.f -o sim_tb

# The log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
